//--- build.f
+incdir+logic
logic/core_pkg.sv
logic/regfile.sv
logic/decode.sv
logic/execute.sv
logic/mem_wb.sv
logic/core_top.sv
tests/tb_core.sv

//--- logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural register count, x0 included
`define NUM_REGS 32

// Data memory depth in words
`define DMEM_WORDS 256

// Common clear value for control registers
`define OP_RST_L '0

`endif

//--- logic/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] rdata_t;
  typedef logic [4:0]       raddr_t;
  typedef logic [`XLEN-1:0] alu_t;

  // Major opcodes handled by decode
  typedef enum logic [6:0] {
    RV_OP     = 7'b0110011,
    RV_OP_IMM = 7'b0010011,
    RV_LUI    = 7'b0110111,
    RV_AUIPC  = 7'b0010111,
    RV_JAL    = 7'b1101111,
    RV_JALR   = 7'b1100111,
    RV_BRANCH = 7'b1100011,
    RV_LOAD   = 7'b0000011,
    RV_STORE  = 7'b0100011
  } opcode_t;

  // Operand source for the ALU inputs
  typedef enum logic [1:0] {
    REG_RF = 2'd0,
    IMM    = 2'd1,
    ZERO   = 2'd2,
    PC     = 2'd3
  } op_sel_t;

  typedef logic [2:0] f3_t;

  // ALU view of funct3
  localparam f3_t RV_F3_ADD_SUB = 3'b000;
  localparam f3_t RV_F3_SLL     = 3'b001;
  localparam f3_t RV_F3_SLT     = 3'b010;
  localparam f3_t RV_F3_SLTU    = 3'b011;
  localparam f3_t RV_F3_XOR     = 3'b100;
  localparam f3_t RV_F3_SRL_SRA = 3'b101;
  localparam f3_t RV_F3_OR      = 3'b110;
  localparam f3_t RV_F3_AND     = 3'b111;

  typedef enum logic {
    RV_SRL = 1'b0,
    RV_SRA = 1'b1
  } shift_t;

  // Branch view of funct3
  typedef enum logic [2:0] {
    RV_B_BEQ  = 3'b000,
    RV_B_BNE  = 3'b001,
    RV_B_BLT  = 3'b100,
    RV_B_BGE  = 3'b101,
    RV_B_BLTU = 3'b110,
    RV_B_BGEU = 3'b111
  } branch_t;

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_t;

  // Load/store view of funct3
  typedef enum logic [2:0] {
    RV_LSU_B  = 3'b000,
    RV_LSU_H  = 3'b001,
    RV_LSU_W  = 3'b010,
    RV_LSU_BU = 3'b100,
    RV_LSU_HU = 3'b101
  } lsu_w_t;

  // Instruction formats, all 32 bits, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    raddr_t     rs2;
    raddr_t     rs1;
    f3_t        funct3;
    raddr_t     rd;
    opcode_t    opcode;
  } s_r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    raddr_t      rs1;
    f3_t         funct3;
    raddr_t      rd;
    opcode_t     opcode;
  } s_i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    raddr_t     rs2;
    raddr_t     rs1;
    f3_t        funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    raddr_t     rs2;
    raddr_t     rs1;
    f3_t        funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } s_b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    raddr_t      rd;
    opcode_t     opcode;
  } s_u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    raddr_t     rd;
    opcode_t    opcode;
  } s_j_type_t;

  typedef union packed {
    s_r_type_t r;
    s_i_type_t i;
    s_s_type_t s;
    s_b_type_t b;
    s_u_type_t u;
    s_j_type_t j;
  } instr_u;

  typedef struct packed {
    rdata_t  pc_dec;
    rdata_t  imm;
    op_sel_t rs1_op;
    op_sel_t rs2_op;
    f3_t     f3;
    logic    f7;
    logic [4:0] shamt;
    shift_t  rshift;
    logic    branch;
    logic    jump;
    lsu_op_t lsu;
    raddr_t  rd_addr;
    logic    we_rd;
  } s_id_ex_t;

  typedef struct packed {
    logic   b_act;
    logic   take_branch;
    rdata_t b_addr;
  } s_branch_t;

  typedef struct packed {
    logic   j_act;
    rdata_t j_addr;
  } s_jump_t;

  typedef struct packed {
    lsu_op_t op_typ;
    lsu_w_t  width;
    rdata_t  addr;
    rdata_t  wdata;
  } s_lsu_op_t;

  typedef struct packed {
    alu_t   result;
    raddr_t rd_addr;
    logic   we_rd;
  } s_ex_mem_wb_t;

  typedef struct packed {
    logic   we;
    raddr_t rd_addr;
    rdata_t wdata;
  } s_wb_t;

endpackage

//--- logic/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                clk,
  input  logic                rst_i,
  input  core_pkg::instr_u    instr_i,
  input  core_pkg::rdata_t    pc_i,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  logic                lsu_bp_i,
  output core_pkg::s_branch_t branch_o,
  output core_pkg::s_jump_t   jump_o,
  output core_pkg::s_wb_t     wb_o
);
  import core_pkg::*;

  s_id_ex_t     id_ex;
  logic         id_valid;
  logic         id_ready;
  raddr_t       rs1_addr, rs2_addr;
  rdata_t       rf_rs1_data, rf_rs2_data;
  rdata_t       id_rs1_data, id_rs2_data;
  s_ex_mem_wb_t ex_mem_wb;
  s_lsu_op_t    lsu;

  decode u_decode (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rf_rs1_data),
    .rs2_data_i    (rf_rs2_data),
    .id_ex_o       (id_ex),
    .rs1_data_o    (id_rs1_data),
    .rs2_data_o    (id_rs2_data),
    .id_valid_o    (id_valid),
    .id_ready_i    (id_ready)
  );

  // Writeback port also feeds the register file
  regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data),
    .wb_i       (wb_o)
  );

  execute u_execute (
    .clk         (clk),
    .rst_i       (rst_i),
    .id_ex_i     (id_ex),
    .rs1_data_i  (id_rs1_data),
    .rs2_data_i  (id_rs2_data),
    .id_valid_i  (id_valid),
    .id_ready_o  (id_ready),
    .lsu_bp_i    (lsu_bp_i),
    .branch_o    (branch_o),
    .jump_o      (jump_o),
    .ex_mem_wb_o (ex_mem_wb),
    .lsu_o       (lsu)
  );

  mem_wb u_mem_wb (
    .clk         (clk),
    .rst_i       (rst_i),
    .ex_mem_wb_i (ex_mem_wb),
    .lsu_i       (lsu),
    .wb_o        (wb_o)
  );

endmodule

//--- logic/decode.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decode (
  input  logic               clk,
  input  logic               rst_i,
  input  core_pkg::instr_u   instr_i,
  input  core_pkg::rdata_t   pc_i,
  input  logic               instr_valid_i,
  output logic               instr_ready_o,
  output core_pkg::raddr_t   rs1_addr_o,
  output core_pkg::raddr_t   rs2_addr_o,
  input  core_pkg::rdata_t   rs1_data_i,
  input  core_pkg::rdata_t   rs2_data_i,
  output core_pkg::s_id_ex_t id_ex_o,
  output core_pkg::rdata_t   rs1_data_o,
  output core_pkg::rdata_t   rs2_data_o,
  output logic               id_valid_o,
  input  logic               id_ready_i
);
  import core_pkg::*;

  s_id_ex_t dec;
  logic     known;
  rdata_t   imm_i, imm_s, imm_b, imm_u, imm_j;

  // Stage advances only when execute can take it
  assign instr_ready_o = id_ready_i;

  // Register indexes sit at the same bits in every format
  assign rs1_addr_o = instr_i.r.rs1;
  assign rs2_addr_o = instr_i.r.rs2;

  always_comb begin : imm_proc
    imm_i = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    imm_s = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
    imm_b = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
             instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    imm_u = {instr_i.u.imm_31_12, 12'b0};
    imm_j = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
             instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
  end : imm_proc

  always_comb begin : dec_proc
    dec         = `OP_RST_L;
    known       = 1'b1;
    dec.pc_dec  = pc_i;
    dec.f3      = instr_i.r.funct3;
    dec.shamt   = instr_i.r.rs2;
    dec.rshift  = shift_t'(instr_i.r.funct7[5]);
    dec.rd_addr = instr_i.r.rd;
    dec.rs1_op  = REG_RF;
    dec.rs2_op  = IMM;

    case (instr_i.r.opcode)
      RV_OP: begin
        dec.rs2_op = REG_RF;
        dec.f7     = instr_i.r.funct7[5];
        dec.we_rd  = 1'b1;
      end
      RV_OP_IMM: begin
        // Bit 30 of an ADDI immediate is not a subtract flag
        dec.imm   = imm_i;
        dec.we_rd = 1'b1;
      end
      RV_LUI: begin
        dec.rs1_op = ZERO;
        dec.imm    = imm_u;
        dec.f3     = RV_F3_ADD_SUB;
        dec.we_rd  = 1'b1;
      end
      RV_AUIPC: begin
        dec.rs1_op = PC;
        dec.imm    = imm_u;
        dec.f3     = RV_F3_ADD_SUB;
        dec.we_rd  = 1'b1;
      end
      RV_JAL: begin
        dec.rs1_op = PC;
        dec.imm    = imm_j;
        dec.f3     = RV_F3_ADD_SUB;
        dec.jump   = 1'b1;
        dec.we_rd  = 1'b1;
      end
      RV_JALR: begin
        dec.imm   = imm_i;
        dec.f3    = RV_F3_ADD_SUB;
        dec.jump  = 1'b1;
        dec.we_rd = 1'b1;
      end
      RV_BRANCH: begin
        dec.rs2_op = REG_RF;
        dec.imm    = imm_b;
        dec.branch = 1'b1;
      end
      RV_LOAD: begin
        dec.imm   = imm_i;
        dec.lsu   = LSU_LOAD;
        dec.we_rd = 1'b1;
      end
      RV_STORE: begin
        dec.imm = imm_s;
        dec.lsu = LSU_STORE;
      end
      default: known = 1'b0;
    endcase

    // x0 is never a write target
    if (dec.rd_addr == '0) begin
      dec.we_rd = 1'b0;
    end

    // Bubble when nothing valid or opcode unknown
    if (!(instr_valid_i && known)) begin
      dec = `OP_RST_L;
    end
  end : dec_proc

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o    <= `OP_RST_L;
      id_valid_o <= 1'b0;
    end else if (id_ready_i) begin
      id_ex_o    <= dec;
      id_valid_o <= instr_valid_i && known;
    end
  end

  // Operands travel with their instruction
  always_ff @(posedge clk) begin
    if (id_ready_i) begin
      rs1_data_o <= rs1_data_i;
      rs2_data_o <= rs2_data_i;
    end
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
    id_ex_o.we_rd |-> (id_ex_o.rd_addr != '0))
    else $error("decode: write enabled for x0");

endmodule

//--- logic/execute.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module execute (
  input  logic                   clk,
  input  logic                   rst_i,
  input  core_pkg::s_id_ex_t     id_ex_i,
  input  core_pkg::rdata_t       rs1_data_i,
  input  core_pkg::rdata_t       rs2_data_i,
  input  logic                   id_valid_i,
  output logic                   id_ready_o,
  input  logic                   lsu_bp_i,
  output core_pkg::s_branch_t    branch_o,
  output core_pkg::s_jump_t      jump_o,
  output core_pkg::s_ex_mem_wb_t ex_mem_wb_o,
  output core_pkg::s_lsu_op_t    lsu_o
);
  import core_pkg::*;

  s_ex_mem_wb_t ex_mem_wb_ff, next_ex_mem_wb;
  s_lsu_op_t    lsu_ff, next_lsu;
  alu_t         op1, op2, res;
  f3_t          alu_f3;

  function automatic logic branch_dec(branch_t op, rdata_t rs1, rdata_t rs2);
    logic take;
    case (op)
      RV_B_BEQ:  take = (rs1 == rs2);
      RV_B_BNE:  take = (rs1 != rs2);
      RV_B_BLT:  take = ($signed(rs1) < $signed(rs2));
      RV_B_BGE:  take = ($signed(rs1) >= $signed(rs2));
      RV_B_BLTU: take = (rs1 < rs2);
      RV_B_BGEU: take = (rs1 >= rs2);
      default:   take = 1'b0;
    endcase
    return take;
  endfunction

  always_comb begin : alu_proc
    case (id_ex_i.rs1_op)
      REG_RF:  op1 = rs1_data_i;
      IMM:     op1 = id_ex_i.imm;
      PC:      op1 = id_ex_i.pc_dec;
      default: op1 = '0;
    endcase

    case (id_ex_i.rs2_op)
      REG_RF:  op2 = rs2_data_i;
      IMM:     op2 = id_ex_i.imm;
      PC:      op2 = id_ex_i.pc_dec;
      default: op2 = '0;
    endcase

    // Address of a load or store is always a sum
    alu_f3 = (id_ex_i.lsu != LSU_NONE) ? RV_F3_ADD_SUB : id_ex_i.f3;

    case (alu_f3)
      RV_F3_ADD_SUB: begin
        res = id_ex_i.f7 ? (op1 - op2) : (op1 + op2);
        // JALR target has bit 0 cleared
        if (id_ex_i.jump && (id_ex_i.rs1_op == REG_RF)) begin
          res[0] = 1'b0;
        end
      end
      RV_F3_SLT:  res = ($signed(op1) < $signed(op2)) ? alu_t'(1) : alu_t'(0);
      RV_F3_SLTU: res = (op1 < op2) ? alu_t'(1) : alu_t'(0);
      RV_F3_XOR:  res = op1 ^ op2;
      RV_F3_OR:   res = op1 | op2;
      RV_F3_AND:  res = op1 & op2;
      // Low operand bits give the amount for both shift forms
      RV_F3_SLL: begin
        res = op1 << op2[4:0];
      end
      RV_F3_SRL_SRA: begin
        res = (id_ex_i.rshift == RV_SRA) ? alu_t'($signed(op1) >>> op2[4:0]) :
                                           (op1 >> op2[4:0]);
      end
      default: res = '0;
    endcase
  end : alu_proc

  always_comb begin : ctrl_proc
    id_ready_o = ~lsu_bp_i;

    branch_o.b_act       = id_ex_i.branch && id_valid_i && ~lsu_bp_i;
    branch_o.take_branch = branch_dec(branch_t'(id_ex_i.f3), rs1_data_i, rs2_data_i);
    branch_o.b_addr      = id_ex_i.pc_dec + id_ex_i.imm;

    jump_o.j_act  = id_ex_i.jump && id_valid_i && ~lsu_bp_i;
    jump_o.j_addr = res;

    next_lsu.op_typ = id_valid_i ? id_ex_i.lsu : LSU_NONE;
    next_lsu.width  = lsu_w_t'(id_ex_i.f3);
    next_lsu.addr   = res;
    next_lsu.wdata  = rs2_data_i;

    // Jumps write back the link address
    next_ex_mem_wb.result  = id_ex_i.jump ? alu_t'(id_ex_i.pc_dec + 'd4) : res;
    next_ex_mem_wb.rd_addr = id_ex_i.rd_addr;
    next_ex_mem_wb.we_rd   = id_ex_i.we_rd && id_valid_i;

    if (lsu_bp_i) begin
      next_ex_mem_wb = ex_mem_wb_ff;
      next_lsu       = lsu_ff;
    end
  end : ctrl_proc

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_mem_wb_ff <= `OP_RST_L;
      lsu_ff       <= `OP_RST_L;
    end else begin
      ex_mem_wb_ff <= next_ex_mem_wb;
      lsu_ff       <= next_lsu;
    end
  end

  assign ex_mem_wb_o = ex_mem_wb_ff;
  assign lsu_o       = lsu_ff;

  a_branch_jump_excl: assert property (@(posedge clk) disable iff (rst_i)
    !(branch_o.b_act && jump_o.j_act))
    else $error("execute: branch and jump active together");

  a_bp_hold: assert property (@(posedge clk) disable iff (rst_i)
    lsu_bp_i |=> ($stable(ex_mem_wb_o) && $stable(lsu_o)))
    else $error("execute: output changed under back-pressure");

endmodule

//--- logic/mem_wb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module mem_wb (
  input  logic                   clk,
  input  logic                   rst_i,
  input  core_pkg::s_ex_mem_wb_t ex_mem_wb_i,
  input  core_pkg::s_lsu_op_t    lsu_i,
  output core_pkg::s_wb_t        wb_o
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  rdata_t           dmem [`DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [3:0]       be;
  logic             store_en;
  rdata_t           st_data, rd_word, shifted, ld_data;

  assign idx      = lsu_i.addr[IDX_W+1:2];
  assign store_en = (lsu_i.op_typ == LSU_STORE) && !rst_i;

  // Replicate the store data so every lane sees it
  always_comb begin : st_proc
    case (lsu_i.width)
      RV_LSU_B, RV_LSU_BU: begin
        be      = 4'b0001 << lsu_i.addr[1:0];
        st_data = {4{lsu_i.wdata[7:0]}};
      end
      RV_LSU_H, RV_LSU_HU: begin
        be      = 4'b0011 << {lsu_i.addr[1], 1'b0};
        st_data = {2{lsu_i.wdata[15:0]}};
      end
      default: begin
        be      = 4'b1111;
        st_data = lsu_i.wdata;
      end
    endcase
  end : st_proc

  always_ff @(posedge clk) begin
    if (store_en) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          dmem[idx][8*b +: 8] <= st_data[8*b +: 8];
        end
      end
    end
  end

  always_comb begin : ld_proc
    rd_word = dmem[idx];
    shifted = rd_word >> {lsu_i.addr[1:0], 3'b000};
    case (lsu_i.width)
      RV_LSU_B:  ld_data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      RV_LSU_H:  ld_data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      RV_LSU_BU: ld_data = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      RV_LSU_HU: ld_data = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      default:   ld_data = rd_word;
    endcase

    wb_o.we      = ex_mem_wb_i.we_rd;
    wb_o.rd_addr = ex_mem_wb_i.rd_addr;
    wb_o.wdata   = (lsu_i.op_typ == LSU_LOAD) ? ld_data : ex_mem_wb_i.result;
  end : ld_proc

  a_dmem_range: assert property (@(posedge clk) disable iff (rst_i)
    (lsu_i.op_typ != LSU_NONE) |-> (lsu_i.addr[`XLEN-1:2] < `DMEM_WORDS))
    else $error("mem_wb: access outside data memory");

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module regfile (
  input  logic             clk,
  input  logic             rst_i,
  input  core_pkg::raddr_t rs1_addr_i,
  input  core_pkg::raddr_t rs2_addr_i,
  output core_pkg::rdata_t rs1_data_o,
  output core_pkg::rdata_t rs2_data_o,
  input  core_pkg::s_wb_t  wb_i
);
  import core_pkg::*;

  // Entry 0 stays cleared, x0 reads are forced to zero anyway
  rdata_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= `OP_RST_L;
      end
    end else if (wb_i.we && (wb_i.rd_addr != '0)) begin
      regs[wb_i.rd_addr] <= wb_i.wdata;
    end
  end

  // Write-first read, so a same-cycle write is seen by decode
  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (wb_i.we && (wb_i.rd_addr == rs1_addr_i)) begin
      rs1_data_o = wb_i.wdata;
    end else begin
      rs1_data_o = regs[rs1_addr_i];
    end

    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (wb_i.we && (wb_i.rd_addr == rs2_addr_i)) begin
      rs2_data_o = wb_i.wdata;
    end else begin
      rs2_data_o = regs[rs2_addr_i];
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_core -f build.f -o tb_core_sim \
  && ./obj_dir/tb_core_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null

grep -qx "ALL TESTS PASSED" sim.log \
  && { echo "Result: pass"; exit 0; } \
  || { echo "Result: fail"; exit 1; }

//--- tests/tb_core.sv
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  logic      clk;
  logic      rst_i;
  instr_u    instr_i;
  rdata_t    pc_i;
  logic      instr_valid_i;
  logic      instr_ready_o;
  logic      lsu_bp_i;
  s_branch_t branch_o;
  s_jump_t   jump_o;
  s_wb_t     wb_o;

  // Architectural state as the testbench expects it
  logic [31:0] ref_regs [32];
  logic [31:0] pc;
  int          seed;
  int          errors;
  int          checks;

  core_top u_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .lsu_bp_i      (lsu_bp_i),
    .branch_o      (branch_o),
    .jump_o        (jump_o),
    .wb_o          (wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic print_summary();
    $display("Summary: %0d checks, %0d errors", checks, errors);
  endtask

  task automatic finish_run();
    print_summary();
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    errors++;
    print_summary();
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic check_wb(input string what, input s_wb_t got, input s_wb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s wb_o: got we=%h rd=%h wdata=%h, expected we=%h rd=%h wdata=%h",
               what, got.we, got.rd_addr, got.wdata, exp.we, exp.rd_addr, exp.wdata);
    end
  endtask

  task automatic check_branch(input string what, input s_branch_t got, input s_branch_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s branch_o: got act=%h take=%h addr=%h, expected act=%h take=%h addr=%h",
               what, got.b_act, got.take_branch, got.b_addr,
               exp.b_act, exp.take_branch, exp.b_addr);
    end
  endtask

  task automatic check_jump(input string what, input s_jump_t got, input s_jump_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s jump_o: got act=%h addr=%h, expected act=%h addr=%h",
               what, got.j_act, got.j_addr, exp.j_act, exp.j_addr);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Present one instruction and hold it until the core takes it
  task automatic issue(input logic [31:0] word);
    int n;
    instr_i       = word;
    pc_i          = pc;
    instr_valid_i = 1'b1;
    n = 0;
    @(posedge clk);
    while (!instr_ready_o && n < TIMEOUT_CYCLES) begin
      n++;
      @(posedge clk);
    end
    if (!instr_ready_o) begin
      abort_run("instruction never accepted");
    end else begin
      @(negedge clk);
      instr_valid_i = 1'b0;
      pc = pc + 32'd4;
    end
  endtask

  task automatic expect_wb(input string what, input logic [4:0] rd, input logic [31:0] value);
    s_wb_t exp;
    int    n;
    n = 0;
    while (!wb_o.we && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!wb_o.we) begin
      abort_run({"no writeback for ", what});
    end else begin
      exp.we      = 1'b1;
      exp.rd_addr = rd;
      exp.wdata   = value;
      check_wb(what, wb_o, exp);
      ref_regs[rd] = value;
    end
  endtask

  task automatic run_wr(input logic [31:0] word, input string what, input logic [4:0] rd,
                        input logic [31:0] value);
    issue(word);
    expect_wb(what, rd, value);
  endtask

  // LUI plus ADDI with the upper part rounded up for the signed low part
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] tmp;
    tmp = value + 32'h800;
    run_wr(enc_u(tmp[31:12], rd), "lui", rd, {tmp[31:12], 12'h000});
    run_wr(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM), "addi", rd,
           ref_regs[rd] + sext12(value[11:0]));
  endtask

  task automatic alu_pair(input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    run_wr(enc_r(7'h00, rs2, rs1, 3'b000, 5'd10), "add", 5'd10, a + b);
    run_wr(enc_r(7'h20, rs2, rs1, 3'b000, 5'd11), "sub", 5'd11, a - b);
    run_wr(enc_r(7'h00, rs2, rs1, 3'b111, 5'd12), "and", 5'd12, a & b);
    run_wr(enc_r(7'h00, rs2, rs1, 3'b110, 5'd13), "or", 5'd13, a | b);
    run_wr(enc_r(7'h00, rs2, rs1, 3'b100, 5'd14), "xor", 5'd14, a ^ b);
    run_wr(enc_r(7'h00, rs2, rs1, 3'b010, 5'd15), "slt", 5'd15,
           {31'd0, $signed(a) < $signed(b)});
    run_wr(enc_r(7'h00, rs2, rs1, 3'b011, 5'd16), "sltu", 5'd16, {31'd0, a < b});
  endtask

  task automatic test_alu();
    for (int r = 1; r <= 4; r++) begin
      load_reg(r[4:0], $random(seed));
    end
    alu_pair(5'd1, 5'd2);
    alu_pair(5'd2, 5'd1);
    alu_pair(5'd3, 5'd4);
    alu_pair(5'd4, 5'd4);
  endtask

  task automatic test_shift();
    logic [31:0] a;
    logic [31:0] r;
    logic [4:0]  sh;
    // Negative source so the arithmetic shift fills with ones
    load_reg(5'd5, $random(seed) | 32'h8000_0000);
    a = ref_regs[5];
    r = $random(seed);
    sh = r[4:0];
    run_wr(enc_i({7'h00, sh}, 5'd5, 3'b001, 5'd17, OPC_OP_IMM), "slli", 5'd17, a << sh);
    run_wr(enc_i({7'h00, sh}, 5'd5, 3'b101, 5'd18, OPC_OP_IMM), "srli", 5'd18, a >> sh);
    run_wr(enc_i({7'h20, sh}, 5'd5, 3'b101, 5'd19, OPC_OP_IMM), "srai", 5'd19,
           $signed(a) >>> sh);
    sh = ref_regs[3][4:0];
    run_wr(enc_r(7'h00, 5'd3, 5'd5, 3'b001, 5'd20), "sll", 5'd20, a << sh);
    run_wr(enc_r(7'h00, 5'd3, 5'd5, 3'b101, 5'd21), "srl", 5'd21, a >> sh);
    run_wr(enc_r(7'h20, 5'd3, 5'd5, 3'b101, 5'd22), "sra", 5'd22, $signed(a) >>> sh);
  endtask

  task automatic test_load_store();
    logic [31:0] word;
    logic [31:0] data;
    logic [7:0]  bt;
    logic [15:0] hw;
    load_reg(5'd6, 32'h0000_0100);
    load_reg(5'd7, $random(seed));
    word = ref_regs[7];
    issue(enc_s(12'd0, 5'd7, 5'd6, 3'b010));
    run_wr(enc_i(12'd0, 5'd6, 3'b010, 5'd23, OPC_LOAD), "lw", 5'd23, word);
    for (int k = 0; k < 4; k++) begin
      bt = word[8*k +: 8];
      run_wr(enc_i(12'(k), 5'd6, 3'b000, 5'd24, OPC_LOAD), "lb", 5'd24, {{24{bt[7]}}, bt});
      run_wr(enc_i(12'(k), 5'd6, 3'b100, 5'd25, OPC_LOAD), "lbu", 5'd25, {24'd0, bt});
    end
    for (int k = 0; k < 2; k++) begin
      hw = word[16*k +: 16];
      run_wr(enc_i(12'(2 * k), 5'd6, 3'b001, 5'd24, OPC_LOAD), "lh", 5'd24,
             {{16{hw[15]}}, hw});
      run_wr(enc_i(12'(2 * k), 5'd6, 3'b101, 5'd25, OPC_LOAD), "lhu", 5'd25, {16'd0, hw});
    end

    // Partial stores must leave the other bytes alone
    load_reg(5'd8, $random(seed) | 32'h0000_8080);
    data = ref_regs[8];
    issue(enc_s(12'd1, 5'd8, 5'd6, 3'b000));
    word[15:8] = data[7:0];
    issue(enc_s(12'd2, 5'd8, 5'd6, 3'b001));
    word[31:16] = data[15:0];
    run_wr(enc_i(12'd0, 5'd6, 3'b010, 5'd23, OPC_LOAD), "lw after sb/sh", 5'd23, word);
    run_wr(enc_i(12'd1, 5'd6, 3'b000, 5'd24, OPC_LOAD), "lb after sb", 5'd24,
           {{24{word[15]}}, word[15:8]});
    run_wr(enc_i(12'd2, 5'd6, 3'b001, 5'd25, OPC_LOAD), "lh after sh", 5'd25,
           {{16{word[31]}}, word[31:16]});
  endtask

  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bpc;
    logic [12:0] off;
    logic        take;
    s_branch_t   exp;
    r = $random(seed);
    off = {r[12:1], 1'b0};
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (f3)
      3'b000:  take = (a == b);
      3'b001:  take = (a != b);
      3'b100:  take = ($signed(a) < $signed(b));
      3'b101:  take = ($signed(a) >= $signed(b));
      3'b110:  take = (a < b);
      default: take = (a >= b);
    endcase
    bpc = pc;
    issue(enc_b(off, rs2, rs1, f3));
    exp.b_act       = 1'b1;
    exp.take_branch = take;
    exp.b_addr      = bpc + {{19{off[12]}}, off};
    check_branch("branch", branch_o, exp);
  endtask

  task automatic test_branch();
    for (int c = 0; c < 8; c++) begin
      if (c != 2 && c != 3) begin
        branch_case(3'(c), 5'd1, 5'd2);
        branch_case(3'(c), 5'd5, 5'd1);
        branch_case(3'(c), 5'd4, 5'd4);
      end
    end
  endtask

  task automatic test_jump();
    logic [31:0] r;
    logic [31:0] jpc;
    logic [20:0] off;
    logic [11:0] imm;
    s_jump_t     exp;
    r = $random(seed);
    off = {r[20:1], 1'b0};
    jpc = pc;
    issue(enc_j(off, 5'd26));
    exp.j_act  = 1'b1;
    exp.j_addr = jpc + {{11{off[20]}}, off};
    check_jump("jal", jump_o, exp);
    expect_wb("jal link", 5'd26, jpc + 32'd4);

    // Immediate chosen so the raw sum is odd
    r = $random(seed);
    imm = {r[11:1], ~ref_regs[1][0]};
    jpc = pc;
    issue(enc_i(imm, 5'd1, 3'b000, 5'd27, OPC_JALR));
    exp.j_act  = 1'b1;
    exp.j_addr = (ref_regs[1] + sext12(imm)) & ~32'h1;
    check_jump("jalr", jump_o, exp);
    expect_wb("jalr link", 5'd27, jpc + 32'd4);
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    logic [11:0] v [3];
    logic [31:0] held_word;
    s_wb_t       exp;
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      v[k] = r[11:0];
    end
    issue(enc_i(v[0], 5'd0, 3'b000, 5'd28, OPC_OP_IMM));
    issue(enc_i(v[1], 5'd0, 3'b000, 5'd29, OPC_OP_IMM));
    exp.we      = 1'b1;
    exp.rd_addr = 5'd28;
    exp.wdata   = sext12(v[0]);
    check_wb("bp before hold", wb_o, exp);
    ref_regs[28] = exp.wdata;

    // First result in execute and second in decode while the third waits
    held_word     = enc_i(v[2], 5'd0, 3'b000, 5'd30, OPC_OP_IMM);
    lsu_bp_i      = 1'b1;
    instr_i       = held_word;
    pc_i          = pc;
    instr_valid_i = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_flag("instr_ready_o", instr_ready_o, 1'b0);
      check_wb("bp hold", wb_o, exp);
    end
    lsu_bp_i = 1'b0;
    issue(held_word);
    expect_wb("bp second", 5'd29, sext12(v[1]));
    @(negedge clk);
    expect_wb("bp third", 5'd30, sext12(v[2]));
  endtask

  initial begin
    seed          = 32'h3a02_5989;
    errors        = 0;
    checks        = 0;
    pc            = 32'h0000_1000;
    rst_i         = 1'b1;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    lsu_bp_i      = 1'b0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // Idle state straight after reset
    check_flag("instr_ready_o", instr_ready_o, 1'b1);
    check_flag("wb_o.we", wb_o.we, 1'b0);
    check_flag("branch_o.b_act", branch_o.b_act, 1'b0);
    check_flag("jump_o.j_act", jump_o.j_act, 1'b0);

    test_alu();
    test_shift();
    test_load_store();
    test_branch();
    test_jump();
    test_backpressure();
    finish_run();
  end

endmodule
